/* source/mem_pkg.sv */
package mem_pkg;

   localparam int ADDR_W    = 10;
   localparam int DATA_W    = 16;
   localparam int MEM_DEPTH = 1024;

   // 1 uses the single output register, 2 adds the pipelined stage behind it
   localparam int RD_LAT    = 1;

   // one access on a RAM port, held by the requester while en is high
   typedef struct packed {
      logic              en;
      logic              we;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } mem_req_t;

endpackage

/* source/cmd_pkg.sv */
package cmd_pkg;

   typedef enum logic [2:0] {
      NOP   = 3'd0,
      WRITE = 3'd1,
      READ  = 3'd2,
      FILL  = 3'd3,
      SUM   = 3'd4
   } op_e;

   // single word access on port B
   typedef struct packed {
      logic [mem_pkg::ADDR_W-1:0] addr;
      logic [mem_pkg::DATA_W-1:0] data;
      logic [2:0]                 rsvd;
   } access_t;

   // region job for the fill or sum engine, len runs from 1 to 1023
   typedef struct packed {
      logic [mem_pkg::ADDR_W-1:0] start_addr;
      logic [mem_pkg::ADDR_W-1:0] len;
      logic [8:0]                 seed;
   } job_t;

   // the opcode decides which view of the payload is meaningful
   typedef union packed {
      access_t acc;
      job_t    job;
   } cmd_payload_u;

   typedef struct packed {
      op_e          op;
      cmd_payload_u payload;
   } host_cmd_t;

endpackage

/* source/bram_dp.sv */
module bram_dp (
   input  logic                       CLKA,
   input  mem_pkg::mem_req_t          a_req,
   input  mem_pkg::mem_req_t          b_req,
   output logic [mem_pkg::DATA_W-1:0] a_rdata,
   output logic [mem_pkg::DATA_W-1:0] b_rdata
);
   import mem_pkg::*;

   logic [DATA_W-1:0] ram [0:MEM_DEPTH-1];
   logic [DATA_W-1:0] a_q;
   logic [DATA_W-1:0] b_q;

   // both ports share the clock, so one process covers them
   always_ff @(posedge CLKA) begin
      if (a_req.en) begin
         if (a_req.we) begin
            ram[a_req.addr] <= a_req.wdata;
            a_q             <= a_req.wdata;   // write first, new word shows on the output
         end else begin
            a_q <= ram[a_req.addr];
         end
      end
      if (b_req.en) begin
         if (b_req.we) begin
            ram[b_req.addr] <= b_req.wdata;
            b_q             <= b_req.wdata;
         end else begin
            b_q <= ram[b_req.addr];
         end
      end
   end

   if (RD_LAT == 2) begin : g_pipe
      logic [DATA_W-1:0] a_q2;
      logic [DATA_W-1:0] b_q2;

      always_ff @(posedge CLKA) begin
         a_q2 <= a_q;
         b_q2 <= b_q;
      end

      assign a_rdata = a_q2;
      assign b_rdata = b_q2;
   end else begin : g_direct
      assign a_rdata = a_q;
      assign b_rdata = b_q;
   end

endmodule

/* source/port_arbiter.sv */
module port_arbiter (
   input  logic                       CLKA,
   input  logic                       rst_n,
   input  mem_pkg::mem_req_t          fill_req,
   input  mem_pkg::mem_req_t          sum_req,
   input  logic [mem_pkg::DATA_W-1:0] ram_rdata,
   output logic                       fill_grant,
   output logic                       sum_grant,
   output mem_pkg::mem_req_t          ram_req,
   output logic [mem_pkg::DATA_W-1:0] eng_rdata
);

   logic last_sum;   // the sum engine won the most recent grant

   // a lone requester always wins, on a tie the previous loser goes first
   always_comb begin
      fill_grant = fill_req.en && (!sum_req.en || last_sum);
      sum_grant  = sum_req.en && (!fill_req.en || !last_sum);
   end

   always_comb begin
      if (fill_grant) begin
         ram_req = fill_req;
      end else if (sum_grant) begin
         ram_req = sum_req;
      end else begin
         ram_req = '0;   // idle port, enable low
      end
   end

   always_ff @(posedge CLKA) begin
      if (!rst_n) begin
         last_sum <= 1'b0;
      end else if (fill_grant || sum_grant) begin
         last_sum <= sum_grant;
      end
   end

   // read data goes to both engines, each one knows when it is its own
   assign eng_rdata = ram_rdata;

endmodule

/* source/fill_engine.sv */
module fill_engine (
   input  logic              CLKA,
   input  logic              rst_n,
   input  logic              start,
   input  cmd_pkg::job_t     job,
   input  logic              grant,
   output mem_pkg::mem_req_t req,
   output logic              busy,
   output logic              done
);
   import mem_pkg::*;

   logic [ADDR_W-1:0] addr;
   logic [ADDR_W-1:0] count;   // words still to write
   logic [DATA_W-1:0] value;

   always_ff @(posedge CLKA) begin
      if (!rst_n) begin
         busy <= 1'b0;
         done <= 1'b0;
      end else begin
         done <= 1'b0;
         if (start && !busy) begin
            busy <= 1'b1;
         end else if (busy && grant && count == ADDR_W'(1)) begin
            busy <= 1'b0;
            done <= 1'b1;   // one cycle after the last granted write
         end
      end
   end

   always_ff @(posedge CLKA) begin
      if (start && !busy) begin
         addr  <= job.start_addr;
         count <= job.len;
         value <= DATA_W'(job.seed);
      end else if (busy && grant) begin
         addr  <= addr + 1'b1;   // wraps at the top of the memory
         count <= count - 1'b1;
         value <= value + 1'b1;
      end
   end

   always_comb begin
      req.en    = busy;
      req.we    = 1'b1;
      req.addr  = addr;
      req.wdata = value;
   end

endmodule

/* source/sum_engine.sv */
module sum_engine (
   input  logic                       CLKA,
   input  logic                       rst_n,
   input  logic                       start,
   input  cmd_pkg::job_t              job,
   input  logic                       grant,
   input  logic [mem_pkg::DATA_W-1:0] rdata,
   output mem_pkg::mem_req_t          req,
   output logic                       busy,
   output logic                       done,
   output logic [mem_pkg::DATA_W-1:0] result
);
   import mem_pkg::*;

   logic [ADDR_W-1:0] addr;
   logic [ADDR_W-1:0] issue_left;   // reads not yet granted
   logic [ADDR_W-1:0] ret_left;     // words not yet added
   logic [DATA_W-1:0] acc;
   logic [RD_LAT-1:0] rd_pipe;
   logic              rd_hit;

   // top bit of the pipe lines up with the RAM output for our own reads
   assign rd_hit = rd_pipe[RD_LAT-1];

   always_ff @(posedge CLKA) begin
      if (!rst_n) begin
         busy    <= 1'b0;
         done    <= 1'b0;
         result  <= '0;
         rd_pipe <= '0;
      end else begin
         done    <= 1'b0;
         rd_pipe <= RD_LAT'({rd_pipe, grant});
         if (start && !busy) begin
            busy <= 1'b1;
         end else if (rd_hit && ret_left == ADDR_W'(1)) begin
            busy   <= 1'b0;
            done   <= 1'b1;
            result <= acc + rdata;   // sum wraps modulo 2^16
         end
      end
   end

   always_ff @(posedge CLKA) begin
      if (start && !busy) begin
         addr       <= job.start_addr;
         issue_left <= job.len;
         ret_left   <= job.len;
         acc        <= '0;
      end else begin
         if (grant) begin
            addr       <= addr + 1'b1;
            issue_left <= issue_left - 1'b1;
         end
         if (rd_hit) begin
            acc      <= acc + rdata;
            ret_left <= ret_left - 1'b1;
         end
      end
   end

   // requests stop once every read is out, the tail of the job only waits for data
   always_comb begin
      req.en    = busy && (issue_left != '0);
      req.we    = 1'b0;
      req.addr  = addr;
      req.wdata = '0;
   end

endmodule

/* source/cmd_decoder.sv */
module cmd_decoder (
   input  logic                       CLKA,
   input  logic                       rst_n,
   input  logic                       cmd_valid,
   input  cmd_pkg::host_cmd_t         cmd,
   input  logic [mem_pkg::DATA_W-1:0] b_rdata,
   input  logic                       fill_busy,
   input  logic                       sum_busy,
   output mem_pkg::mem_req_t          b_req,
   output logic                       fill_start,
   output logic                       sum_start,
   output cmd_pkg::job_t              job,
   output logic                       rd_valid,
   output logic [mem_pkg::DATA_W-1:0] rd_data
);
   import mem_pkg::*;
   import cmd_pkg::*;

   logic [RD_LAT:0] rd_pipe;   // one bit per cycle a host read spends in flight
   logic            is_read;
   logic            is_job;

   assign is_read = cmd_valid && cmd.op == READ;
   assign is_job  = cmd_valid && (cmd.op == FILL || cmd.op == SUM);

   always_ff @(posedge CLKA) begin
      if (!rst_n) begin
         b_req      <= '0;
         fill_start <= 1'b0;
         sum_start  <= 1'b0;
         rd_pipe    <= '0;
      end else begin
         b_req.en   <= 1'b0;
         fill_start <= 1'b0;
         sum_start  <= 1'b0;
         rd_pipe    <= {rd_pipe[RD_LAT-1:0], is_read};
         if (cmd_valid) begin
            case (cmd.op)
               WRITE, READ: begin
                  b_req.en    <= 1'b1;
                  b_req.we    <= cmd.op == WRITE;
                  b_req.addr  <= cmd.payload.acc.addr;
                  b_req.wdata <= cmd.payload.acc.data;
               end
               // a start still in flight counts as busy too
               FILL: fill_start <= !(fill_busy || fill_start);
               SUM:  sum_start  <= !(sum_busy || sum_start);
               default: ;
            endcase
         end
      end
   end

   // the engine copies the job on its start pulse, so one register serves both
   always_ff @(posedge CLKA) begin
      if (is_job) begin
         job <= cmd.payload.job;
      end
   end

   assign rd_valid = rd_pipe[RD_LAT];
   assign rd_data  = b_rdata;

endmodule

/* source/scratch_mem_top.sv */
module scratch_mem_top (
   input  logic                       CLKA,
   input  logic                       rst_n,
   input  logic                       cmd_valid,
   input  cmd_pkg::host_cmd_t         cmd,
   output logic                       rd_valid,
   output logic [mem_pkg::DATA_W-1:0] rd_data,
   output logic                       fill_done,
   output logic                       sum_done,
   output logic [mem_pkg::DATA_W-1:0] sum_result,
   output logic                       busy
);
   import mem_pkg::*;
   import cmd_pkg::*;

   mem_req_t          b_req;
   mem_req_t          a_req;
   mem_req_t          fill_req;
   mem_req_t          sum_req;
   job_t              job;
   logic              fill_start;
   logic              sum_start;
   logic              fill_busy;
   logic              sum_busy;
   logic              fill_grant;
   logic              sum_grant;
   logic [DATA_W-1:0] a_rdata;
   logic [DATA_W-1:0] b_rdata;
   logic [DATA_W-1:0] eng_rdata;

   cmd_decoder dec_i (
      .CLKA       (CLKA),
      .rst_n      (rst_n),
      .cmd_valid  (cmd_valid),
      .cmd        (cmd),
      .b_rdata    (b_rdata),
      .fill_busy  (fill_busy),
      .sum_busy   (sum_busy),
      .b_req      (b_req),
      .fill_start (fill_start),
      .sum_start  (sum_start),
      .job        (job),
      .rd_valid   (rd_valid),
      .rd_data    (rd_data)
   );

   fill_engine fill_i (
      .CLKA  (CLKA),
      .rst_n (rst_n),
      .start (fill_start),
      .job   (job),
      .grant (fill_grant),
      .req   (fill_req),
      .busy  (fill_busy),
      .done  (fill_done)
   );

   sum_engine sum_i (
      .CLKA   (CLKA),
      .rst_n  (rst_n),
      .start  (sum_start),
      .job    (job),
      .grant  (sum_grant),
      .rdata  (eng_rdata),
      .req    (sum_req),
      .busy   (sum_busy),
      .done   (sum_done),
      .result (sum_result)
   );

   port_arbiter arb_i (
      .CLKA       (CLKA),
      .rst_n      (rst_n),
      .fill_req   (fill_req),
      .sum_req    (sum_req),
      .ram_rdata  (a_rdata),
      .fill_grant (fill_grant),
      .sum_grant  (sum_grant),
      .ram_req    (a_req),
      .eng_rdata  (eng_rdata)
   );

   bram_dp ram_i (
      .CLKA    (CLKA),
      .a_req   (a_req),
      .b_req   (b_req),
      .a_rdata (a_rdata),
      .b_rdata (b_rdata)
   );

   assign busy = fill_busy | sum_busy;

endmodule

/* sim/scratch_mem_tb.sv */
module scratch_mem_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import mem_pkg::*;
   import cmd_pkg::*;

   localparam int ENGINE_LIMIT = 2100;   // cycles allowed for one engine job

   logic              CLKA;
   logic              rst_n;
   logic              cmd_valid;
   host_cmd_t         cmd;
   logic              rd_valid;
   logic [DATA_W-1:0] rd_data;
   logic              fill_done;
   logic              sum_done;
   logic [DATA_W-1:0] sum_result;
   logic              busy;

   string       t_name[$];
   string       t_op[$];
   logic [15:0] t_addr[$];
   logic [15:0] t_len[$];
   logic [15:0] t_data[$];
   logic [15:0] t_exp[$];

   int seed         = 5;
   int checks       = 0;
   int val_errors   = 0;
   int other_errors = 0;
   int fill_cnt     = 0;
   int sum_cnt      = 0;
   int fill_target  = 0;   // fill_done pulses expected so far
   int sum_target   = 0;
   bit loaded       = 1'b0;
   bit load_ok;

   scratch_mem_top dut_i (
      .CLKA       (CLKA),
      .rst_n      (rst_n),
      .cmd_valid  (cmd_valid),
      .cmd        (cmd),
      .rd_valid   (rd_valid),
      .rd_data    (rd_data),
      .fill_done  (fill_done),
      .sum_done   (sum_done),
      .sum_result (sum_result),
      .busy       (busy)
   );

   initial CLKA = 1'b0;
   always #4 CLKA = ~CLKA;

   // done pulses can land while the host is busy with another command
   always @(posedge CLKA) begin
      if (rst_n && fill_done) fill_cnt <= fill_cnt + 1;
      if (rst_n && sum_done) sum_cnt <= sum_cnt + 1;
   end

   task automatic next_cycle();
      @(posedge CLKA);
      #1;
   endtask

   task automatic check_value(input string name, input logic [15:0] exp,
                              input logic [15:0] act);
      checks++;
      assert (act === exp) else begin
         val_errors++;
         $display("FAILED %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic report_problem(input string msg);
      other_errors++;
      $display("ERROR: %s", msg);
   endtask

   function automatic host_cmd_t access_cmd(input op_e op, input logic [15:0] addr,
                                            input logic [15:0] data);
      host_cmd_t c;
      c                  = '0;
      c.op               = op;
      c.payload.acc.addr = addr[ADDR_W-1:0];
      c.payload.acc.data = data;
      return c;
   endfunction

   function automatic host_cmd_t job_cmd(input op_e op, input logic [15:0] start,
                                         input logic [15:0] len, input logic [15:0] sd);
      host_cmd_t c;
      c                        = '0;
      c.op                     = op;
      c.payload.job.start_addr = start[ADDR_W-1:0];
      c.payload.job.len        = len[ADDR_W-1:0];
      c.payload.job.seed       = sd[8:0];
      return c;
   endfunction

   // the DUT samples the one-cycle strobe at the second edge
   task automatic send_cmd(input host_cmd_t c);
      @(posedge CLKA);
      #1;
      cmd       = c;
      cmd_valid = 1'b1;
      next_cycle();
      cmd_valid = 1'b0;
      cmd       = '0;
   endtask

   task automatic wait_engines(input string name);
      int n;
      n = 0;
      while ((fill_cnt < fill_target || sum_cnt < sum_target) && n < ENGINE_LIMIT) begin
         next_cycle();
         n++;
      end
      assert (fill_cnt >= fill_target && sum_cnt >= sum_target) else
         report_problem({"engine job did not finish in ", name});
   endtask

   task automatic do_read(input int i);
      int cycles;
      cycles = 0;
      send_cmd(access_cmd(READ, t_addr[i], 16'h0));
      while (!rd_valid && cycles < 16) begin
         next_cycle();
         cycles++;
      end
      assert (rd_valid) else report_problem({"no read data came back in ", t_name[i]});
      if (rd_valid) begin
         check_value({t_name[i], ".latency"}, 16'(1 + RD_LAT), 16'(cycles + 1));
         check_value(t_name[i], t_exp[i], rd_data);
      end
   endtask

   task automatic run_test(input int i);
      case (t_op[i])
         "IDLE": begin
            check_value({t_name[i], ".rd_valid"}, 16'h0, 16'(rd_valid));
            check_value({t_name[i], ".fill_done"}, 16'h0, 16'(fill_done));
            check_value({t_name[i], ".sum_done"}, 16'h0, 16'(sum_done));
            check_value({t_name[i], ".busy"}, 16'h0, 16'(busy));
            check_value({t_name[i], ".sum_result"}, t_exp[i], sum_result);
         end
         "WRITE": send_cmd(access_cmd(WRITE, t_addr[i], t_data[i]));
         "READ":  do_read(i);
         "FILL", "FILLNB": begin
            fill_target++;
            send_cmd(job_cmd(FILL, t_addr[i], t_len[i], t_data[i]));
            if (t_op[i] == "FILL") wait_engines(t_name[i]);
         end
         "FILLDROP": send_cmd(job_cmd(FILL, t_addr[i], t_len[i], t_data[i]));
         "SUM": begin
            sum_target++;
            send_cmd(job_cmd(SUM, t_addr[i], t_len[i], 16'h0));
            wait_engines(t_name[i]);
            check_value(t_name[i], t_exp[i], sum_result);
         end
         "SYNC": begin
            wait_engines(t_name[i]);
            repeat (4) next_cycle();
            assert (!busy) else report_problem({"DUT still busy after ", t_name[i]});
            assert (fill_cnt == fill_target && sum_cnt == sum_target) else
               report_problem({"extra done pulse seen by ", t_name[i]});
         end
         default: report_problem({"unknown opcode in test ", t_name[i]});
      endcase
   endtask

   task automatic load_tests(output bit ok);
      int          fd;
      int          n;
      string       line;
      string       nm;
      string       op;
      logic [15:0] a;
      logic [15:0] l;
      logic [15:0] d;
      logic [15:0] e;
      ok = 1'b0;
      fd = $fopen("sim/scratch_mem_tests.txt", "r");
      if (fd != 0) begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
               n = $sscanf(line, "%s %s %h %h %h %h", nm, op, a, l, d, e);
               if (n == 6) begin
                  t_name.push_back(nm);
                  t_op.push_back(op);
                  t_addr.push_back(a);
                  t_len.push_back(l);
                  t_data.push_back(d);
                  t_exp.push_back(e);
               end else begin
                  report_problem("malformed line in the test file");
               end
            end
         end
         $fclose(fd);
         ok = t_name.size() > 0;
      end
   endtask

   initial begin
      int idle;
      rst_n     = 1'b0;
      cmd_valid = 1'b0;
      cmd       = '0;
      load_tests(load_ok);
      if (!load_ok) begin
         $display("ERROR: no tests could be read from the test file");
         $display("Simulation FAILED");
         $finish;
      end else begin
         loaded = 1'b1;
         repeat (5) @(posedge CLKA);
         #1 rst_n = 1'b1;
         for (int i = 0; i < t_name.size(); i++) begin
            idle = $unsigned($random(seed)) % 4;
            repeat (idle) next_cycle();
            run_test(i);
         end
         $display("checks %0d, value errors %0d, other errors %0d",
                  checks, val_errors, other_errors);
         if (val_errors == 0 && other_errors == 0) begin
            $display("Simulation PASSED");
         end else begin
            $display("Simulation FAILED");
         end
         $finish;
      end
   end

   // budget scales with the number of tests in the file
   initial begin
      wait (loaded);
      repeat (t_name.size() * ENGINE_LIMIT + 100) @(posedge CLKA);
      $display("ERROR: timeout, the tests did not finish in time");
      $display("Simulation FAILED");
      $finish;
   end

endmodule

/* sim/scratch_mem_tests.txt */
# name op addr len data expected, numeric fields in hex, data is the seed for FILL
# ops: IDLE WRITE READ FILL FILLNB FILLDROP SUM SYNC
idle_after_reset IDLE 000 000 0000 0000
wr_low WRITE 005 000 beef 0000
rd_low READ 005 000 0000 beef
wr_top WRITE 3ff 000 1234 0000
rd_top READ 3ff 000 0000 1234
fill_r1 FILL 100 010 01f0 0000
rd_r1_first READ 100 000 0000 01f0
rd_r1_mid READ 108 000 0000 01f8
rd_r1_last READ 10f 000 0000 01ff
sum_r1 SUM 100 010 0000 1f78
fill_wrap FILL 3f0 020 0100 0000
rd_wrap_first READ 3f0 000 0000 0100
rd_wrap_last READ 00f 000 0000 011f
sum_wrap SUM 3f0 020 0000 21f0
fill_big FILL 200 0c8 01ff 0000
sum_big SUM 200 0c8 0000 dcf4
fill_par FILLNB 040 040 0020 0000
sum_par SUM 200 0c8 0000 dcf4
sync_par SYNC 000 000 0000 0000
rd_par_mid READ 060 000 0000 0040
sum_par_fill SUM 040 040 0000 0fe0
fill_first FILLNB 300 020 00aa 0000
fill_drop FILLDROP 300 020 0155 0000
sync_drop SYNC 000 000 0000 0000
rd_drop_first READ 300 000 0000 00aa
rd_drop_last READ 31f 000 0000 00c9
sum_drop SUM 300 020 0000 1730

/* verilog.f */
source/mem_pkg.sv
source/cmd_pkg.sv
source/bram_dp.sv
source/port_arbiter.sv
source/fill_engine.sv
source/sum_engine.sv
source/cmd_decoder.sv
source/scratch_mem_top.sv
sim/scratch_mem_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -f verilog.f --top-module scratch_mem_tb \
		-Mdir obj_dir -o scratch_mem_sim
	out=$$(./obj_dir/scratch_mem_sim); \
	echo "$$out"; \
	echo "$$out" | grep -qxF "Simulation PASSED"

clean:
	rm -rf obj_dir
